// ==== hw/mem_pkg.sv ====
// ---------------------------------------------------------------------
// one-hot class values must match the decode table feeding this stage
// ---------------------------------------------------------------------
`default_nettype none

package mem_pkg;

	// ---------------------------------------------------------------------
	// widths with a meaning
	// ---------------------------------------------------------------------
	// data or address word
	typedef logic [31:0] word_t;
	// one-hot instruction class
	typedef logic [15:0] encoding_t;
	// rv32i func3 field
	typedef logic [2:0]  func3_t;
	// one enable per byte lane
	typedef logic [3:0]  byte_en_t;
	// exception code, see bit positions below
	typedef logic [3:0]  exc_t;

	// ---------------------------------------------------------------------
	// instruction classes handled by this stage
	// ---------------------------------------------------------------------
	localparam encoding_t ENC_LOAD   = 16'h0004;
	localparam encoding_t ENC_STORE  = 16'h0008;
	localparam encoding_t ENC_FLOAD  = 16'h0010;
	localparam encoding_t ENC_FSTORE = 16'h0020;

	// load func3
	localparam func3_t F3_LB  = 3'b000;
	localparam func3_t F3_LH  = 3'b001;
	localparam func3_t F3_LW  = 3'b010;
	localparam func3_t F3_LBU = 3'b100;
	localparam func3_t F3_LHU = 3'b101;
	// store func3
	localparam func3_t F3_SB  = 3'b000;
	localparam func3_t F3_SH  = 3'b001;
	localparam func3_t F3_SW  = 3'b010;

	// access width on the bus
	typedef enum logic [1:0] {
		SIZE_BYTE,
		SIZE_HWORD,
		SIZE_WORD
	} mem_size_e;

	// exception bit positions
	localparam int unsigned EXC_TIMEOUT        = 3;
	localparam int unsigned EXC_FUNC3          = 2;
	localparam int unsigned EXC_WORD_MISALIGN  = 1;
	localparam int unsigned EXC_HWORD_MISALIGN = 0;

	// bus cycles without acknowledge before giving up
	localparam int unsigned TIMEOUT_CYCLES_DEF = 16;

endpackage

`default_nettype wire

// ==== hw/mem_access_if.sv ====
// ---------------------------------------------------------------------
// purely combinational bundle, valid only while the operands are held
// ---------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface mem_access_if
	import mem_pkg::*;
();

	// access kind, both low when an early exception is raised
	logic      is_load;
	logic      is_store;
	// effective address and lane-shifted store data
	word_t     addr;
	word_t     wdata;
	byte_en_t  be;
	// width and extension of a load
	mem_size_e size;
	logic      is_signed;
	// early exceptions, timeout bit is never set here
	exc_t      exc;

	// decoder drives everything
	modport producer (
		output is_load, is_store, addr, wdata, be, size, is_signed, exc
	);

	// sequencer launches the bus transaction
	modport sequencer (
		input is_load, is_store, addr, wdata, be, exc
	);

	// aligner only needs the lane and the extension
	modport aligner (
		input addr, size, is_signed
	);

endinterface

`default_nettype wire

// ==== hw/memory_reference_controller.sv ====
// ---------------------------------------------------------------------
// fload/fstore are word accesses, func3 ignored for them
// ---------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module memory_reference_controller
	import mem_pkg::*;
(
	input  wire encoding_t encoding_i,
	input  wire func3_t    func3_i,
	input  wire word_t     src1_i,
	input  wire word_t     src2_i,
	input  wire word_t     imm_i,
	mem_access_if.producer acc
);

	logic      is_mem_load;
	logic      is_mem_store;
	logic      func3_bad;
	mem_size_e size_d;
	logic      signed_d;
	word_t     addr_d;
	byte_en_t  be_d;
	word_t     store_mask;
	logic [4:0] lane_shift;
	exc_t      exc_d;

	// ---------------------------------------------------------------------
	// class and address
	// ---------------------------------------------------------------------
	assign is_mem_load  = (encoding_i == ENC_LOAD) || (encoding_i == ENC_FLOAD);
	assign is_mem_store = (encoding_i == ENC_STORE) || (encoding_i == ENC_FSTORE);

	// base plus immediate, zero for anything else
	assign addr_d = (is_mem_load || is_mem_store) ? src1_i + imm_i : '0;

	// ---------------------------------------------------------------------
	// width and signedness from func3
	// ---------------------------------------------------------------------
	always_comb begin
		size_d    = SIZE_WORD;
		signed_d  = 1'b0;
		func3_bad = 1'b0;
		case (encoding_i)
			ENC_LOAD: begin
				case (func3_i)
					F3_LB: begin
						size_d   = SIZE_BYTE;
						signed_d = 1'b1;
					end
					F3_LH: begin
						size_d   = SIZE_HWORD;
						signed_d = 1'b1;
					end
					F3_LW:  size_d = SIZE_WORD;
					F3_LBU: size_d = SIZE_BYTE;
					F3_LHU: size_d = SIZE_HWORD;
					default: func3_bad = 1'b1;
				endcase
			end
			ENC_STORE: begin
				case (func3_i)
					F3_SB:   size_d = SIZE_BYTE;
					F3_SH:   size_d = SIZE_HWORD;
					F3_SW:   size_d = SIZE_WORD;
					default: func3_bad = 1'b1;
				endcase
			end
			// float classes and non-memory ops stay at word
			default: size_d = SIZE_WORD;
		endcase
	end

	// ---------------------------------------------------------------------
	// lane placement
	// ---------------------------------------------------------------------
	assign lane_shift = {addr_d[1:0], 3'b000};

	always_comb begin
		case (size_d)
			SIZE_BYTE: begin
				be_d       = 4'b0001 << addr_d[1:0];
				store_mask = 32'h0000_00ff;
			end
			SIZE_HWORD: begin
				be_d       = 4'b0011 << addr_d[1:0];
				store_mask = 32'h0000_ffff;
			end
			default: begin
				be_d       = 4'b1111;
				store_mask = 32'hffff_ffff;
			end
		endcase
	end

	// ---------------------------------------------------------------------
	// early exceptions
	// ---------------------------------------------------------------------
	// misalignment only judged once the width is known
	always_comb begin
		exc_d            = '0;
		exc_d[EXC_FUNC3] = func3_bad;
		if ((is_mem_load || is_mem_store) && !func3_bad) begin
			exc_d[EXC_WORD_MISALIGN]  = (size_d == SIZE_WORD) && (addr_d[1:0] != 2'b00);
			exc_d[EXC_HWORD_MISALIGN] = (size_d == SIZE_HWORD) && addr_d[0];
		end
	end

	// any exception suppresses the bus access
	assign acc.is_load   = is_mem_load && (exc_d == '0);
	assign acc.is_store  = is_mem_store && (exc_d == '0);
	assign acc.addr      = addr_d;
	assign acc.wdata     = (src2_i & store_mask) << lane_shift;
	assign acc.be        = be_d;
	assign acc.size      = size_d;
	assign acc.is_signed = signed_d;
	assign acc.exc       = exc_d;

endmodule

`default_nettype wire

// ==== hw/mem_access_fsm.sv ====
// ---------------------------------------------------------------------
// one operation at a time; operands must stay stable until op_ack_o
// ---------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module mem_access_fsm
	import mem_pkg::*;
(
	input  wire            clk_i,
	input  wire            reset_i,
	input  wire            op_req_i,
	output logic           op_ack_o,
	mem_access_if.sequencer acc,
	output logic           bus_req_o,
	output logic           bus_we_o,
	output word_t          bus_addr_o,
	output word_t          bus_wdata_o,
	output byte_en_t       bus_be_o,
	input  wire            bus_ack_i,
	output logic           timer_run_o,
	input  wire            timer_expired_i,
	output logic           capture_o,
	output exc_t           exception_o
);

	typedef enum logic [1:0] {
		IDLE,
		BUS_REQ,
		BUS_RELEASE,
		DONE
	} state_e;

	state_e state_q;
	state_e state_d;
	exc_t   exc_q;
	logic   launch;

	// operation accepted this cycle
	assign launch = (state_q == IDLE) && op_req_i;

	// ---------------------------------------------------------------------
	// next state
	// ---------------------------------------------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (op_req_i) begin
					// early exceptions and non-memory ops skip the bus
					state_d = (acc.is_load || acc.is_store) ? BUS_REQ : DONE;
				end
			end
			// leave on acknowledge or on timeout
			BUS_REQ:     if (bus_ack_i || timer_expired_i) state_d = BUS_RELEASE;
			// memory must drop its acknowledge first
			BUS_RELEASE: if (!bus_ack_i) state_d = DONE;
			DONE:        if (!op_req_i) state_d = IDLE;
			default:     state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q <= IDLE;
			exc_q   <= '0;
		end else begin
			state_q <= state_d;
			if (launch) begin
				exc_q <= {1'b0, acc.exc[2:0]};
			end else if ((state_q == BUS_REQ) && !bus_ack_i && timer_expired_i) begin
				exc_q[EXC_TIMEOUT] <= 1'b1;
			end
		end
	end

	// bus fields frozen for the whole transaction
	always_ff @(posedge clk_i) begin
		if (launch) begin
			bus_we_o    <= acc.is_store;
			bus_addr_o  <= acc.addr;
			bus_wdata_o <= acc.wdata;
			bus_be_o    <= acc.be;
		end
	end

	// ---------------------------------------------------------------------
	// outputs
	// ---------------------------------------------------------------------
	assign bus_req_o   = (state_q == BUS_REQ);
	assign op_ack_o    = (state_q == DONE);
	assign timer_run_o = (state_q == BUS_REQ);
	// read data is valid together with the acknowledge
	assign capture_o   = (state_q == BUS_REQ) && bus_ack_i && !bus_we_o;
	assign exception_o = exc_q;

	// ---------------------------------------------------------------------
	// checks
	// ---------------------------------------------------------------------
	// registered fields track the held operation for the whole request
	a_bus_fields_stable: assert property (@(posedge clk_i) disable iff (reset_i)
		bus_req_o
		|-> ({bus_we_o, bus_addr_o, bus_wdata_o, bus_be_o}
			== {acc.is_store, acc.addr, acc.wdata, acc.be}));

	// completion only once the bus side is fully quiet
	a_ack_after_bus: assert property (@(posedge clk_i) disable iff (reset_i)
		$rose(op_ack_o) |-> !bus_req_o && !$past(bus_ack_i));

endmodule

`default_nettype wire

// ==== hw/bus_timeout_timer.sv ====
// ---------------------------------------------------------------------
// TIMEOUT_CYCLES must be at least 1
// ---------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module bus_timeout_timer
	import mem_pkg::*;
#(
	parameter int unsigned TIMEOUT_CYCLES = TIMEOUT_CYCLES_DEF
) (
	input  wire  clk_i,
	input  wire  reset_i,
	input  wire  run_i,
	output logic expired_o
);

	localparam int unsigned CNT_W = $clog2(TIMEOUT_CYCLES + 1);

	typedef logic [CNT_W-1:0] count_t;

	localparam count_t LIMIT = count_t'(TIMEOUT_CYCLES);

	count_t count_q;

	// counts while running, saturates at the limit
	always_ff @(posedge clk_i) begin
		if (reset_i || !run_i) begin
			count_q <= '0;
		end else if (count_q != LIMIT) begin
			count_q <= count_q + 1'b1;
		end
	end

	// held high until run_i drops
	assign expired_o = run_i && (count_q == LIMIT);

	// expiry needs a full window of running cycles behind it
	a_expiry_needs_run: assert property (@(posedge clk_i) disable iff (reset_i)
		expired_o |-> run_i && $past(run_i, TIMEOUT_CYCLES));

endmodule

`default_nettype wire

// ==== hw/load_data_aligner.sv ====
// ---------------------------------------------------------------------
// result holds until the next load acknowledge
// ---------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module load_data_aligner
	import mem_pkg::*;
(
	input  wire          clk_i,
	input  wire          reset_i,
	input  wire          capture_i,
	input  wire word_t   rdata_i,
	mem_access_if.aligner acc,
	output word_t        load_data_o
);

	word_t lane_word;
	word_t extended;

	// addressed lane moved down to bit 0
	assign lane_word = rdata_i >> {acc.addr[1:0], 3'b000};

	// ---------------------------------------------------------------------
	// extension by width
	// ---------------------------------------------------------------------
	always_comb begin
		case (acc.size)
			SIZE_BYTE: begin
				if (acc.is_signed) begin
					extended = {{24{lane_word[7]}}, lane_word[7:0]};
				end else begin
					extended = {24'h00_0000, lane_word[7:0]};
				end
			end
			SIZE_HWORD: begin
				if (acc.is_signed) begin
					extended = {{16{lane_word[15]}}, lane_word[15:0]};
				end else begin
					extended = {16'h0000, lane_word[15:0]};
				end
			end
			// full word, no shift needed
			default: extended = rdata_i;
		endcase
	end

	// ---------------------------------------------------------------------
	// result register
	// ---------------------------------------------------------------------
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			load_data_o <= '0;
		end else if (capture_i) begin
			load_data_o <= extended;
		end
	end

endmodule

`default_nettype wire

// ==== hw/mem_stage.sv ====
// ---------------------------------------------------------------------
// four-phase handshakes on both sides, one operation in flight
// ---------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module mem_stage
	import mem_pkg::*;
#(
	parameter int unsigned TIMEOUT_CYCLES = TIMEOUT_CYCLES_DEF
) (
	input  wire            clk_i,
	input  wire            reset_i,
	// operation side
	input  wire            op_req_i,
	output logic           op_ack_o,
	input  wire encoding_t encoding_i,
	input  wire func3_t    func3_i,
	input  wire word_t     src1_i,
	input  wire word_t     src2_i,
	input  wire word_t     imm_i,
	// data bus side
	output logic           bus_req_o,
	output logic           bus_we_o,
	output word_t          bus_addr_o,
	output word_t          bus_wdata_o,
	output byte_en_t       bus_be_o,
	input  wire            bus_ack_i,
	input  wire word_t     bus_rdata_i,
	// results, valid while op_ack_o is high
	output word_t          load_data_o,
	output exc_t           exception_o
);

	logic timer_run;
	logic timer_expired;
	logic capture;

	// decoded access shared by the blocks below
	mem_access_if acc_if ();

	// ---------------------------------------------------------------------
	// decode
	// ---------------------------------------------------------------------
	memory_reference_controller u_decode (
		.encoding_i (encoding_i),
		.func3_i    (func3_i),
		.src1_i     (src1_i),
		.src2_i     (src2_i),
		.imm_i      (imm_i),
		.acc        (acc_if.producer)
	);

	// ---------------------------------------------------------------------
	// sequencing and timeout
	// ---------------------------------------------------------------------
	mem_access_fsm u_fsm (
		.clk_i           (clk_i),
		.reset_i         (reset_i),
		.op_req_i        (op_req_i),
		.op_ack_o        (op_ack_o),
		.acc             (acc_if.sequencer),
		.bus_req_o       (bus_req_o),
		.bus_we_o        (bus_we_o),
		.bus_addr_o      (bus_addr_o),
		.bus_wdata_o     (bus_wdata_o),
		.bus_be_o        (bus_be_o),
		.bus_ack_i       (bus_ack_i),
		.timer_run_o     (timer_run),
		.timer_expired_i (timer_expired),
		.capture_o       (capture),
		.exception_o     (exception_o)
	);

	bus_timeout_timer #(
		.TIMEOUT_CYCLES (TIMEOUT_CYCLES)
	) u_timer (
		.clk_i     (clk_i),
		.reset_i   (reset_i),
		.run_i     (timer_run),
		.expired_o (timer_expired)
	);

	// load result path
	load_data_aligner u_align (
		.clk_i       (clk_i),
		.reset_i     (reset_i),
		.capture_i   (capture),
		.rdata_i     (bus_rdata_i),
		.acc         (acc_if.aligner),
		.load_data_o (load_data_o)
	);

endmodule

`default_nettype wire

// ==== tests/tb_mem_responder.sv ====
// ---------------------------------------------------------------------
// 64 words, aliased below DEAD_BASE; dead region is never acknowledged
// ---------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_mem_responder
	import mem_pkg::*;
#(
	parameter logic [15:0] SEED      = 16'd49,
	parameter int unsigned DEAD_BASE = 32'h400
) (
	input  wire           clk_i,
	input  wire           req_i,
	input  wire           we_i,
	input  wire word_t    addr_i,
	input  wire word_t    wdata_i,
	input  wire byte_en_t be_i,
	output logic          ack_o,
	output word_t         rdata_o
);

	word_t       mem [64];
	logic [15:0] lfsr_q;
	int unsigned delay;

	// taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// 0 to 5 cycles, three fresh bits
	function automatic int unsigned pick_delay();
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < 3; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			r = {r[30:0], lfsr_q[0]};
		end
		return r % 6;
	endfunction

	initial begin
		lfsr_q  = SEED;
		ack_o   = 1'b0;
		rdata_o = '0;
		// fill follows the word address
		for (int i = 0; i < 64; i++) begin
			mem[i] = word_t'(i * 4) ^ 32'h5a5a_0000;
		end
		// outputs move 1 ns after the edge, inputs looked at then too
		forever begin
			@(posedge clk_i);
			#1;
			if (req_i && (addr_i < DEAD_BASE)) begin
				delay = pick_delay();
				repeat (delay) begin
					@(posedge clk_i);
					#1;
				end
				if (we_i) begin
					for (int b = 0; b < 4; b++) begin
						if (be_i[b]) mem[addr_i[7:2]][b*8 +: 8] = wdata_i[b*8 +: 8];
					end
				end else begin
					rdata_o = mem[addr_i[7:2]];
				end
				ack_o = 1'b1;
				// hold until the stage lets go of the request
				while (req_i) begin
					@(posedge clk_i);
					#1;
				end
				ack_o = 1'b0;
			end else if (req_i) begin
				// dead region reads as zero
				rdata_o = '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tests/tb_mem_stage.sv ====
// ---------------------------------------------------------------------
// live accesses stay below 0x100; dead region at 0x400 and up
// ---------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_mem_stage
	import mem_pkg::*;
();

	localparam int unsigned TIMEOUT   = 16;
	localparam int unsigned N_WORDS   = 64;
	localparam int unsigned N_NARROW  = 32;
	localparam int unsigned N_EARLY   = 24;
	localparam int unsigned N_DEAD    = 4;
	localparam int unsigned N_OPS     = 2 * N_WORDS + 3 * N_NARROW + N_EARLY + N_DEAD;
	localparam int unsigned DEAD_BASE = 32'h400;

	logic      clk;
	logic      reset;
	logic      op_req;
	logic      op_ack;
	encoding_t encoding;
	func3_t    func3;
	word_t     src1;
	word_t     src2;
	word_t     imm;
	logic      bus_req;
	logic      bus_we;
	word_t     bus_addr;
	word_t     bus_wdata;
	byte_en_t  bus_be;
	logic      bus_ack;
	word_t     bus_rdata;
	word_t     load_data;
	exc_t      exception;

	// model and bookkeeping
	word_t       shadow [64];
	logic [15:0] lfsr_q;
	word_t       res_data;
	exc_t        res_exc;
	logic        res_bus;
	int unsigned res_cycles;
	int unsigned errors;
	int unsigned checks;
	int unsigned tests;
	int unsigned failed_tests;

	mem_stage #(
		.TIMEOUT_CYCLES (TIMEOUT)
	) dut (
		.clk_i       (clk),
		.reset_i     (reset),
		.op_req_i    (op_req),
		.op_ack_o    (op_ack),
		.encoding_i  (encoding),
		.func3_i     (func3),
		.src1_i      (src1),
		.src2_i      (src2),
		.imm_i       (imm),
		.bus_req_o   (bus_req),
		.bus_we_o    (bus_we),
		.bus_addr_o  (bus_addr),
		.bus_wdata_o (bus_wdata),
		.bus_be_o    (bus_be),
		.bus_ack_i   (bus_ack),
		.bus_rdata_i (bus_rdata),
		.load_data_o (load_data),
		.exception_o (exception)
	);

	tb_mem_responder #(
		.SEED      (16'd49),
		.DEAD_BASE (DEAD_BASE)
	) u_mem (
		.clk_i   (clk),
		.req_i   (bus_req),
		.we_i    (bus_we),
		.addr_i  (bus_addr),
		.wdata_i (bus_wdata),
		.be_i    (bus_be),
		.ack_o   (bus_ack),
		.rdata_o (bus_rdata)
	);

	always #5 clk = ~clk;

	// ---------------------------------------------------------------------
	// random source and reference model
	// ---------------------------------------------------------------------
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// one lfsr step per bit taken
	function automatic word_t rand_bits(input int unsigned n);
		word_t r;
		r = '0;
		for (int unsigned i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			r = {r[30:0], lfsr_q[0]};
		end
		return r;
	endfunction

	function automatic logic is_mem(input encoding_t enc);
		return (enc == ENC_LOAD) || (enc == ENC_STORE) || (enc == ENC_FLOAD) ||
			(enc == ENC_FSTORE);
	endfunction

	// bytes moved; 0 flags an unknown func3
	function automatic int unsigned width_of(input encoding_t enc, input func3_t f3);
		if (enc == ENC_LOAD) begin
			case (f3)
				F3_LB, F3_LBU: return 1;
				F3_LH, F3_LHU: return 2;
				F3_LW:         return 4;
				default:       return 0;
			endcase
		end
		if (enc == ENC_STORE) begin
			case (f3)
				F3_SB:   return 1;
				F3_SH:   return 2;
				F3_SW:   return 4;
				default: return 0;
			endcase
		end
		return 4;
	endfunction

	function automatic exc_t predict_exc(input encoding_t enc, input func3_t f3, input word_t addr);
		exc_t        e;
		int unsigned w;
		e = '0;
		w = width_of(enc, f3);
		if (is_mem(enc)) begin
			if (w == 0) e[EXC_FUNC3] = 1'b1;
			else if ((w == 4) && (addr[1:0] != 2'b00)) e[EXC_WORD_MISALIGN] = 1'b1;
			else if ((w == 2) && addr[0]) e[EXC_HWORD_MISALIGN] = 1'b1;
		end
		return e;
	endfunction

	function automatic word_t predict_load(input encoding_t enc, input func3_t f3, input word_t addr);
		word_t       w;
		logic [7:0]  b;
		logic [15:0] h;
		w = shadow[addr[7:2]];
		b = w[addr[1:0] * 8 +: 8];
		h = w[addr[1] * 16 +: 16];
		if (enc == ENC_FLOAD) return w;
		case (f3)
			F3_LB:   return {{24{b[7]}}, b};
			F3_LBU:  return {24'd0, b};
			F3_LH:   return {{16{h[15]}}, h};
			F3_LHU:  return {16'd0, h};
			default: return w;
		endcase
	endfunction

	// only the addressed bytes change
	task automatic store_model(input word_t addr, input word_t data, input int unsigned w);
		for (int unsigned b = 0; b < w; b++) begin
			shadow[addr[7:2]][(addr[1:0] + b) * 8 +: 8] = data[b*8 +: 8];
		end
	endtask

	// ---------------------------------------------------------------------
	// operation handshake and checks
	// ---------------------------------------------------------------------
	// called 1 ns after an edge; address split into random base and offset
	task automatic run_op(input encoding_t enc, input func3_t f3, input word_t addr,
		input word_t data);
		word_t r;
		r          = rand_bits(12);
		imm        = {{20{r[11]}}, r[11:0]};
		src1       = addr - imm;
		src2       = data;
		encoding   = enc;
		func3      = f3;
		op_req     = 1'b1;
		res_bus    = 1'b0;
		res_cycles = 0;
		do begin
			@(posedge clk);
			#1;
			res_cycles++;
			if (bus_req) res_bus = 1'b1;
		end while (!op_ack);
		res_data = load_data;
		res_exc  = exception;
		op_req   = 1'b0;
		do begin
			@(posedge clk);
			#1;
		end while (op_ack);
	endtask

	task automatic check_value(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		if (!cond) begin
			errors++;
			$display("Error at %0t ns: %s", $time, what);
		end
	endtask

	task automatic finish_test(input string name, input int unsigned err_before);
		tests++;
		if (errors == err_before) begin
			$display("test %s: ok", name);
		end else begin
			failed_tests++;
			$display("test %s: %0d errors", name, errors - err_before);
		end
	endtask

	// ---------------------------------------------------------------------
	// watchdog, sized for the slowest case of every operation
	// ---------------------------------------------------------------------
	initial begin
		#((10 + N_OPS * (TIMEOUT + 20)) * 10);
		$display("watchdog expired before all tests completed");
		$display("Testbench failed");
		$finish;
	end

	// ---------------------------------------------------------------------
	// test sequence
	// ---------------------------------------------------------------------
	initial begin
		word_t       addr;
		word_t       data;
		word_t       r;
		encoding_t   enc;
		func3_t      f3;
		exc_t        exp_exc;
		int unsigned err0;
		int unsigned made;
		lfsr_q       = 16'd49;
		errors       = 0;
		checks       = 0;
		tests        = 0;
		failed_tests = 0;
		clk          = 1'b0;
		reset        = 1'b1;
		op_req       = 1'b0;
		encoding     = '0;
		func3        = '0;
		src1         = '0;
		src2         = '0;
		imm          = '0;
		repeat (10) @(posedge clk);
		#1;
		err0 = errors;
		check_true(!op_ack && !bus_req, "op_ack_o or bus_req_o high during reset");
		finish_test("reset", err0);
		reset = 1'b0;

		// every word written, then read back
		err0 = errors;
		for (int i = 0; i < N_WORDS; i++) begin
			addr = word_t'(i * 4);
			data = rand_bits(32);
			enc  = (rand_bits(1) != 0) ? ENC_FSTORE : ENC_STORE;
			run_op(enc, F3_SW, addr, data);
			check_value("exception_o", word_t'(res_exc), '0);
			store_model(addr, data, 4);
		end
		for (int i = 0; i < N_WORDS; i++) begin
			addr = word_t'(i * 4);
			enc  = (rand_bits(1) != 0) ? ENC_FLOAD : ENC_LOAD;
			run_op(enc, F3_LW, addr, rand_bits(32));
			check_value("load_data_o", res_data, predict_load(enc, F3_LW, addr));
			check_value("exception_o", word_t'(res_exc), '0);
		end
		finish_test("word round trip", err0);

		// narrow store, full word read, narrow read in the same word
		err0 = errors;
		for (int i = 0; i < N_NARROW; i++) begin
			r    = rand_bits(9);
			addr = {24'd0, r[7:0]};
			if (r[8]) addr[0] = 1'b0;
			f3   = r[8] ? F3_SH : F3_SB;
			data = rand_bits(32);
			run_op(ENC_STORE, f3, addr, data);
			check_value("exception_o", word_t'(res_exc), '0);
			store_model(addr, data, r[8] ? 2 : 1);
			run_op(ENC_LOAD, F3_LW, {addr[31:2], 2'b00}, rand_bits(32));
			check_value("load_data_o", res_data, predict_load(ENC_LOAD, F3_LW, addr));
			r = rand_bits(4);
			case (r[1:0])
				2'd0:    f3 = F3_LB;
				2'd1:    f3 = F3_LBU;
				2'd2:    f3 = F3_LH;
				default: f3 = F3_LHU;
			endcase
			addr = {addr[31:2], r[3:2]};
			if (r[1]) addr[0] = 1'b0;
			run_op(ENC_LOAD, f3, addr, rand_bits(32));
			check_value("load_data_o", res_data, predict_load(ENC_LOAD, f3, addr));
			check_value("exception_o", word_t'(res_exc), '0);
		end
		finish_test("narrow accesses", err0);

		// candidates that would reach the bus are skipped
		err0 = errors;
		made = 0;
		while (made < N_EARLY) begin
			r = rand_bits(19);
			case (r[1:0])
				2'd0:    enc = ENC_LOAD;
				2'd1:    enc = ENC_STORE;
				2'd2:    enc = r[2] ? ENC_FLOAD : ENC_FSTORE;
				default: enc = encoding_t'(16'h0001 << r[7:4]);
			endcase
			f3      = r[10:8];
			addr    = {24'd0, r[18:11]};
			exp_exc = predict_exc(enc, f3, addr);
			if (is_mem(enc) && (exp_exc == '0)) continue;
			run_op(enc, f3, addr, rand_bits(32));
			made++;
			check_value("exception_o", word_t'(res_exc), word_t'(exp_exc));
			check_true(!res_bus, "bus_req_o raised for an operation without bus access");
			check_true(res_cycles == 1, "op_ack_o not one cycle after op_req_i was sampled");
		end
		finish_test("early exceptions", err0);

		// dead region never answers
		err0    = errors;
		exp_exc = '0;
		exp_exc[EXC_TIMEOUT] = 1'b1;
		for (int i = 0; i < N_DEAD; i++) begin
			r    = rand_bits(9);
			addr = DEAD_BASE + {22'd0, r[7:0], 2'b00};
			enc  = r[8] ? ENC_STORE : ENC_LOAD;
			run_op(enc, F3_LW, addr, rand_bits(32));
			check_value("exception_o", word_t'(res_exc), word_t'(exp_exc));
			check_true(res_bus, "no bus request for an access to the dead region");
		end
		finish_test("timeout", err0);

		$display("%0d tests, %0d failed, %0d checks, %0d errors", tests, failed_tests, checks,
			errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
hw/mem_pkg.sv
hw/mem_access_if.sv
hw/memory_reference_controller.sv
hw/mem_access_fsm.sv
hw/bus_timeout_timer.sv
hw/load_data_aligner.sv
hw/mem_stage.sv
tests/tb_mem_responder.sv
tests/tb_mem_stage.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_mem_stage
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
